/* compile.f */
+incdir+common
common/uart_rx_pkg.sv
rx_frame/rx_line_sampler.sv
rx_frame/rx_deserializer.sv
logic/rx_fifo.sv
logic/rx_wb_regs.sv
logic/uart_rx_top.sv
verif/tb_clock.sv
verif/uart_rx_tb.sv

/* Makefile */
TOP = uart_rx_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
		--top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/uart_rx_tb.sv */
// ----------------------------------------
// uart receiver testbench
// serial frames in, Wishbone reads out
// ----------------------------------------
`default_nettype none
`include "uart_rx_macros.svh"

module uart_rx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_rx_pkg::*;

  localparam int BIT_CLKS    = `RX_OVERSAMPLE * `RX_BAUD_DIV; // clocks per serial bit
  localparam int ACK_TIMEOUT = 16;
  localparam int POLL_LIMIT  = 64;
  localparam logic [`WB_ADDR_W-1:0] A_DATA   = `RX_ADDR_DATA;
  localparam logic [`WB_ADDR_W-1:0] A_STATUS = `RX_ADDR_STATUS;
  localparam logic [`WB_ADDR_W-1:0] A_CTRL   = `RX_ADDR_CTRL;

  logic     clk;
  logic     aresetn;
  logic     rx;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  integer   seed;
  int       checks;
  int       mismatches;
  int       other_errors;
  rx_char_t exp_q[$];
  rx_char_t got_q[$];
  string    name_q[$];
  logic [7:0] sent[`RX_FIFO_DEPTH + 2];

  tb_clock tb_clock_inst (.clk(clk), .aresetn(aresetn));

  uart_rx_top uart_rx_top_inst (
    .clk     (clk),
    .aresetn (aresetn),
    .rx      (rx),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
  );

  // ----------------------------------------
  // reference model and compare tasks
  // ----------------------------------------
  function automatic rx_char_t expected_char(input logic [7:0] b, input rx_cfg_t cfg,
                                             input logic flip_par, input logic stop_low);
    rx_char_t c;
    c.data        = cfg.bit8 ? b : {1'b0, b[6:0]}; // 7-bit mode clears bit 7
    c.parity_err  = cfg.parity_en & flip_par;
    c.framing_err = stop_low;
    return c;
  endfunction

  task automatic check_char(input string name, input rx_char_t exp, input rx_char_t act);
    checks++;
    if (act !== exp)
    begin
      mismatches++;
      $display("CHECK FAILED %s: expected data=%h pe=%b fe=%b, actual data=%h pe=%b fe=%b",
               name, exp.data, exp.parity_err, exp.framing_err,
               act.data, act.parity_err, act.framing_err);
    end
  endtask

  task automatic check_status(input string name, input rx_status_t exp, input rx_status_t act);
    checks++;
    if (act !== exp)
    begin
      mismatches++;
      $display(
        "CHECK FAILED %s: expected not_empty=%b overflow=%b, actual not_empty=%b overflow=%b",
        name, exp.not_empty, exp.overflow, act.not_empty, act.overflow);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      mismatches++;
      $display("CHECK FAILED %s: expected valid=%b, actual valid=%b", name, exp, act);
    end
  endtask

  // pairs every data read with the oldest expected character
  always @(negedge clk)
  begin
    if (got_q.size() != 0)
    begin
      if (exp_q.size() == 0)
      begin
        $display("ERROR: a character was read while none was expected");
        other_errors++;
        got_q.delete(0);
      end
      else
        check_char(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
    end
  end

  // ----------------------------------------
  // serial driver
  // ----------------------------------------
  task automatic send_bit(input logic v);
    @(posedge clk);
    rx <= v;
    repeat (BIT_CLKS - 1) @(posedge clk);
  endtask

  task automatic send_frame(input logic [7:0] b, input rx_cfg_t cfg,
                            input logic flip_par, input logic stop_low);
    logic par;
    par = 1'b0;
    send_bit(1'b0); // start
    for (int i = 0; i < (cfg.bit8 ? 8 : 7); i++)
    begin
      send_bit(b[i]); // lsb first
      par = par ^ b[i];
    end
    if (cfg.parity_en)
      send_bit(par ^ cfg.odd_n_even ^ flip_par);
    send_bit(!stop_low);
    send_bit(1'b1); // one idle bit between frames
  endtask

  // ----------------------------------------
  // Wishbone classic master
  // ----------------------------------------
  task automatic wb_cycle(input logic we, input logic [`WB_ADDR_W-1:0] addr,
                          input logic [7:0] wdat, output logic [15:0] rdat);
    int  n;
    logic got;
    n    = 0;
    got  = 1'b0;
    rdat = 'x;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdat};
    while (!got && n < ACK_TIMEOUT)
    begin
      @(negedge clk);
      n++;
      if (wb_rsp.ack)
      begin
        got  = 1'b1;
        rdat = wb_rsp.dat;
      end
    end
    if (!got)
    begin
      $display("ERROR: no Wishbone ack within %0d cycles at address %0d", ACK_TIMEOUT, addr);
      other_errors++;
    end
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic wb_write_cfg(input rx_cfg_t cfg);
    logic [15:0] unused;
    wb_cycle(1'b1, A_CTRL, {5'b00000, cfg}, unused);
  endtask

  task automatic read_status(input string name, input rx_status_t exp);
    logic [15:0] d;
    wb_cycle(1'b0, A_STATUS, 8'h00, d);
    check_status(name, exp, rx_status_t'(d[1:0]));
  endtask

  // expected character is queued before the read result reaches the compare process
  task automatic read_char(input string name, input rx_char_t exp, input logic exp_valid);
    logic [15:0] d;
    exp_q.push_back(exp);
    name_q.push_back(name);
    wb_cycle(1'b0, A_DATA, 8'h00, d);
    check_valid(name, exp_valid, d[10]);
    got_q.push_back(rx_char_t'(d[9:0]));
  endtask

  task automatic wait_char(input string name);
    logic [15:0] d;
    rx_status_t  st;
    int          n;
    n  = 0;
    st = '0;
    while (!st.not_empty && n < POLL_LIMIT)
    begin
      wb_cycle(1'b0, A_STATUS, 8'h00, d);
      st = rx_status_t'(d[1:0]);
      n++;
    end
    if (n == POLL_LIMIT && !st.not_empty)
    begin
      $display("ERROR: %s: no character arrived after %0d status polls", name, n);
      other_errors++;
    end
  endtask

  task automatic receive_one(input string name, input logic [7:0] b, input rx_cfg_t cfg,
                             input logic flip_par, input logic stop_low);
    send_frame(b, cfg, flip_par, stop_low);
    wait_char(name);
    read_char(name, expected_char(b, cfg, flip_par, stop_low), 1'b1);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial
  begin
    int      n;
    rx_cfg_t cfg;
    rx     <= 1'b1; // idle line
    wb_req <= '0;
    seed         = 113;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    n = 0;
    while (aresetn !== 1'b1 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (aresetn !== 1'b1)
    begin
      $display("ERROR: reset never released");
      other_errors++;
    end
    repeat (2) @(posedge clk);

    // after reset
    read_status("reset status", '{not_empty: 1'b0, overflow: 1'b0});
    read_char("reset data", '0, 1'b0);

    // 8N1 random bytes
    cfg = '{bit8: 1'b1, parity_en: 1'b0, odd_n_even: 1'b0};
    wb_write_cfg(cfg);
    for (int i = 0; i < 20; i++)
      receive_one($sformatf("8N1 byte %0d", i), 8'($random(seed)), cfg, 1'b0, 1'b0);
    read_status("8N1 drained", '{not_empty: 1'b0, overflow: 1'b0});

    // 7E1 then 8O1 with the parity bit flipped in every other frame
    for (int k = 0; k < 2; k++)
    begin
      cfg = (k == 0) ? '{bit8: 1'b0, parity_en: 1'b1, odd_n_even: 1'b0}
                     : '{bit8: 1'b1, parity_en: 1'b1, odd_n_even: 1'b1};
      wb_write_cfg(cfg);
      for (int i = 0; i < 4; i++)
        receive_one($sformatf("parity cfg %0d frame %0d", k, i), 8'($random(seed)), cfg,
                    1'(i), 1'b0);
    end

    // framing error followed by a clean frame
    cfg = '{bit8: 1'b1, parity_en: 1'b0, odd_n_even: 1'b0};
    wb_write_cfg(cfg);
    receive_one("stop low", 8'($random(seed)), cfg, 1'b0, 1'b1);
    receive_one("after stop low", 8'($random(seed)), cfg, 1'b0, 1'b0);

    // overflow drops the last two frames
    for (int i = 0; i < `RX_FIFO_DEPTH + 2; i++)
    begin
      sent[i] = 8'($random(seed));
      send_frame(sent[i], cfg, 1'b0, 1'b0);
    end
    read_status("overflow set", '{not_empty: 1'b1, overflow: 1'b1});
    read_status("overflow cleared", '{not_empty: 1'b1, overflow: 1'b0});
    for (int i = 0; i < `RX_FIFO_DEPTH; i++)
      read_char($sformatf("overflow read %0d", i), expected_char(sent[i], cfg, 1'b0, 1'b0),
                1'b1);
    read_status("overflow drained", '{not_empty: 1'b0, overflow: 1'b0});

    // short glitch on the idle line
    @(posedge clk);
    rx <= 1'b0;
    repeat (`RX_BAUD_DIV - 1) @(posedge clk);
    rx <= 1'b1;
    repeat (11 * BIT_CLKS) @(posedge clk);
    read_status("glitch", '{not_empty: 1'b0, overflow: 1'b0});

    // let the compare process catch up
    n = 0;
    while (got_q.size() != 0 && n < 10)
    begin
      @(negedge clk);
      n++;
    end
    if (got_q.size() != 0 || exp_q.size() != 0)
    begin
      $display("ERROR: %0d expected characters were never compared", exp_q.size());
      other_errors++;
    end

    $display("checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
// ----------------------------------------
// testbench clock and reset source
// ----------------------------------------
`default_nettype none

module tb_clock (
  output logic clk,
  output logic aresetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial
  begin
    aresetn = 1'b0;
    repeat (2) @(posedge clk);
    aresetn <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/uart_rx_top.sv */
// -------------------------------------
// uart receiver top level
// -------------------------------------
`default_nettype none

module uart_rx_top (
  input  logic                 clk,
  input  logic                 aresetn,
  input  logic                 rx,
  input  uart_rx_pkg::wb_req_t wb_req,
  output uart_rx_pkg::wb_rsp_t wb_rsp
);

  import uart_rx_pkg::*;

  logic     tick;
  logic     rx_filtered;
  logic     char_valid;
  rx_char_t char_out;
  rx_char_t pop_data;
  logic     empty;
  logic     dropped;
  logic     pop;
  rx_cfg_t  cfg;

  rx_line_sampler rx_line_sampler_inst (
    .clk         (clk),
    .aresetn     (aresetn),
    .rx          (rx),
    .tick        (tick),
    .rx_filtered (rx_filtered)
  );

  rx_deserializer rx_deserializer_inst (
    .clk         (clk),
    .aresetn     (aresetn),
    .tick        (tick),
    .rx_filtered (rx_filtered),
    .cfg         (cfg),
    .char_valid  (char_valid),
    .char_out    (char_out)
  );

  // full is not needed outside, drops are reported instead
  rx_fifo #(.payload_t(rx_char_t)) rx_fifo_inst (
    .clk       (clk),
    .aresetn   (aresetn),
    .push      (char_valid),
    .push_data (char_out),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (),
    .empty     (empty),
    .dropped   (dropped)
  );

  rx_wb_regs rx_wb_regs_inst (
    .clk      (clk),
    .aresetn  (aresetn),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .empty    (empty),
    .dropped  (dropped),
    .pop_data (pop_data),
    .pop      (pop),
    .cfg      (cfg)
  );

endmodule

`default_nettype wire

/* logic/rx_wb_regs.sv */
// -------------------------------------
// wishbone classic register slave
// control, status and data registers, sticky overflow
// -------------------------------------
`default_nettype none
`include "uart_rx_macros.svh"

module rx_wb_regs (
  input  logic                  clk,
  input  logic                  aresetn,
  input  uart_rx_pkg::wb_req_t  wb_req,
  output uart_rx_pkg::wb_rsp_t  wb_rsp,
  input  logic                  empty,
  input  logic                  dropped,
  input  uart_rx_pkg::rx_char_t pop_data,
  output logic                  pop,
  output uart_rx_pkg::rx_cfg_t  cfg
);

  import uart_rx_pkg::*;

  localparam logic [`WB_ADDR_W-1:0] ADDR_DATA   = `RX_ADDR_DATA;
  localparam logic [`WB_ADDR_W-1:0] ADDR_STATUS = `RX_ADDR_STATUS;
  localparam logic [`WB_ADDR_W-1:0] ADDR_CTRL   = `RX_ADDR_CTRL;

  logic        req;
  logic        take;      // new cycle accepted this clock
  logic        ack;
  logic        served;    // acked, waiting for stb to drop
  logic        data_hit;  // data read of a non-empty FIFO
  logic        stat_hit;
  logic        overflow;
  rx_status_t  status;
  logic [15:0] rd_mux;
  logic [15:0] rd_dat;

  assign req    = wb_req.cyc && wb_req.stb;
  assign take   = req && !ack && !served;
  assign status = '{not_empty: !empty, overflow: overflow | dropped};
  assign pop    = ack && data_hit;

  always_comb
  begin
    case (wb_req.adr)
      ADDR_DATA:   rd_mux = empty ? 16'h0000 : {5'b00000, 1'b1, pop_data}; // bit 10 valid
      ADDR_STATUS: rd_mux = {14'b0, status};
      ADDR_CTRL:   rd_mux = {13'b0, cfg};
      default:     rd_mux = 16'h0000;
    endcase
  end

  // -------------------------------------
  // handshake, config and overflow flag
  // -------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      ack      <= 1'b0;
      served   <= 1'b0;
      data_hit <= 1'b0;
      stat_hit <= 1'b0;
      overflow <= 1'b0;
      cfg      <= '{bit8: 1'b1, parity_en: 1'b0, odd_n_even: 1'b0};
    end
    else
    begin
      ack      <= take;
      data_hit <= take && !wb_req.we && (wb_req.adr == ADDR_DATA) && !empty;
      stat_hit <= take && !wb_req.we && (wb_req.adr == ADDR_STATUS);
      if (!req)
        served <= 1'b0;
      else if (ack)
        served <= 1'b1;
      if (take && wb_req.we && (wb_req.adr == ADDR_CTRL))
        cfg <= rx_cfg_t'(wb_req.dat[2:0]);
      if (dropped)
        overflow <= 1'b1; // a new loss wins over the clear
      else if (ack && stat_hit)
        overflow <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      rd_dat <= rd_mux;
  end

  assign wb_rsp = '{ack: ack, dat: rd_dat};

  a_ack_after_req : assert property (@(posedge clk) disable iff (!aresetn)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

`default_nettype wire

/* logic/rx_fifo.sv */
// -------------------------------------
// synchronous FIFO, any payload type
// refuses pushes when full and flags the loss
// -------------------------------------
`default_nettype none
`include "uart_rx_macros.svh"

module rx_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `RX_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     aresetn,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     full,
  output logic     empty,
  output logic     dropped
);

  localparam int AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNTW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CNTW-1:0] count;
  logic            do_push;
  logic            do_pop;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == CNTW'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty; // pop on empty ignored
  assign pop_data = mem[rd_ptr];   // head always visible

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      dropped <= 1'b0;
    end
    else
    begin
      dropped <= push && full;
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  a_count_bound : assert property (@(posedge clk) disable iff (!aresetn)
    count <= CNTW'(DEPTH));

endmodule

`default_nettype wire

/* rx_frame/rx_deserializer.sv */
// -------------------------------------
// serial frame deserializer
// start detect, data and parity sampling, stop check
// -------------------------------------
`default_nettype none
`include "uart_rx_macros.svh"

module rx_deserializer (
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  tick,
  input  logic                  rx_filtered,
  input  uart_rx_pkg::rx_cfg_t  cfg,
  output logic                  char_valid,
  output uart_rx_pkg::rx_char_t char_out
);

  import uart_rx_pkg::*;

  localparam int CW = $clog2(`RX_OVERSAMPLE);

  rx_state_e     state;
  logic [CW-1:0] tick_cnt;  // ticks within the current bit
  logic [3:0]    bit_idx;   // data and parity bits taken so far
  logic [3:0]    last_idx;  // index of the final data or parity bit
  logic [3:0]    n_data;
  rx_cfg_t       cfg_l;     // config frozen for the frame
  logic [7:0]    shift;
  logic          par_acc;   // xor over data and parity bits
  logic          mid_bit;
  logic          start_ok;

  assign mid_bit  = tick && (tick_cnt == CW'(`RX_OVERSAMPLE - 1));
  assign start_ok = tick && !rx_filtered && (tick_cnt == CW'(`RX_HALF_BIT - 1));
  assign n_data   = cfg_l.bit8 ? 4'd8 : 4'd7;

  // -------------------------------------
  // frame FSM
  // -------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state      <= st_idle;
      tick_cnt   <= '0;
      bit_idx    <= '0;
      last_idx   <= 4'd7;
      cfg_l      <= '{bit8: 1'b1, parity_en: 1'b0, odd_n_even: 1'b0};
      par_acc    <= 1'b0;
      char_valid <= 1'b0;
    end
    else
    begin
      char_valid <= 1'b0;
      case (state)
        st_idle:
        begin
          if (tick)
          begin
            if (rx_filtered)
              tick_cnt <= '0; // glitch or idle line restarts the count
            else if (start_ok)
            begin
              state    <= st_data;
              tick_cnt <= '0;
              bit_idx  <= '0;
              par_acc  <= 1'b0;
              cfg_l    <= cfg;
              last_idx <= (cfg.bit8 ? 4'd7 : 4'd6) + {3'b000, cfg.parity_en};
            end
            else
              tick_cnt <= tick_cnt + 1'b1;
          end
        end
        st_data:
        begin
          if (mid_bit)
          begin
            tick_cnt <= '0;
            par_acc  <= par_acc ^ rx_filtered;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == last_idx)
              state <= st_stop;
          end
          else if (tick)
            tick_cnt <= tick_cnt + 1'b1;
        end
        st_stop:
        begin
          if (mid_bit)
          begin
            tick_cnt   <= '0;
            char_valid <= 1'b1;
            state      <= st_wait;
          end
          else if (tick)
            tick_cnt <= tick_cnt + 1'b1;
        end
        default: // st_wait lets a low stop bit clear
        begin
          if (tick)
          begin
            if (rx_filtered || (tick_cnt == CW'(`RX_HALF_BIT - 1)))
            begin
              state    <= st_idle;
              tick_cnt <= '0;
            end
            else
              tick_cnt <= tick_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // shift register and character output
  always_ff @(posedge clk)
  begin
    if ((state == st_data) && mid_bit && (bit_idx < n_data))
      shift <= {rx_filtered, shift[7:1]}; // lsb first
    if ((state == st_stop) && mid_bit)
    begin
      char_out.data        <= cfg_l.bit8 ? shift : {1'b0, shift[7:1]};
      char_out.parity_err  <= cfg_l.parity_en & (par_acc ^ cfg_l.odd_n_even);
      char_out.framing_err <= ~rx_filtered;
    end
  end

  a_state_legal : assert property (@(posedge clk) disable iff (!aresetn)
    state inside {st_idle, st_data, st_stop, st_wait});

endmodule

`default_nettype wire

/* rx_frame/rx_line_sampler.sv */
// -------------------------------------
// serial line sampler
// baud tick divider and 3-sample majority glitch filter
// -------------------------------------
`default_nettype none
`include "uart_rx_macros.svh"

module rx_line_sampler (
  input  logic clk,
  input  logic aresetn,
  input  logic rx,
  output logic tick,
  output logic rx_filtered
);

  localparam int DIV_W = (`RX_BAUD_DIV > 1) ? $clog2(`RX_BAUD_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       samples; // [2] is the newest

  // tick generator, one clock every RX_BAUD_DIV clocks
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else if (div_cnt == DIV_W'(`RX_BAUD_DIV - 1))
    begin
      div_cnt <= '0;
      tick    <= 1'b1;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
      tick    <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      samples <= 3'b111; // idle line is high
    else if (tick)
      samples <= {rx, samples[2:1]};
  end

  // any two of three
  assign rx_filtered = (samples[0] & samples[1]) | (samples[0] & samples[2]) |
                       (samples[1] & samples[2]);

  a_tick_single : assert property (@(posedge clk) disable iff (!aresetn)
    (`RX_BAUD_DIV > 1) && tick |=> !tick);

endmodule

`default_nettype wire

/* common/uart_rx_pkg.sv */
// -------------------------------------
// uart receiver shared types
// -------------------------------------
`default_nettype none
`include "uart_rx_macros.svh"

package uart_rx_pkg;

  typedef struct packed {
    logic bit8;       // 8 data bits when set, else 7
    logic parity_en;
    logic odd_n_even; // odd parity when set
  } rx_cfg_t;

  typedef struct packed {
    logic [7:0] data; // bit 7 zero in 7-bit mode
    logic       parity_err;
    logic       framing_err;
  } rx_char_t;

  typedef struct packed {
    logic not_empty;
    logic overflow;
  } rx_status_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [7:0]            dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_data = 2'd1,
    st_stop = 2'd2,
    st_wait = 2'd3
  } rx_state_e;

endpackage

`default_nettype wire

/* common/uart_rx_macros.svh */
// -------------------------------------
// uart receiver build constants
// oversampling, baud divisor, buffer size, register map
// -------------------------------------
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

`define RX_OVERSAMPLE  16 // ticks per bit
`define RX_HALF_BIT    8  // start edge to mid-bit
`define RX_BAUD_DIV    4  // clocks per tick
`define RX_FIFO_DEPTH  8  // receive buffer entries

// register word addresses
`define RX_ADDR_DATA   0
`define RX_ADDR_STATUS 1
`define RX_ADDR_CTRL   2
`define WB_ADDR_W      2

`endif
